/* hw/uart_io_params.svh */
// uart io bridge constants
`ifndef UART_IO_PARAMS_SVH
`define UART_IO_PARAMS_SVH

// byte pacing, in clk cycles
`define UART_IO_BYTE_DELAY 15

// packet framing
`define UART_IO_CHAR_L    8'h4C // request id
`define UART_IO_CHAR_S    8'h53 // response id
`define UART_IO_PKT_BYTES 13    // id + three words

// command codes, full word
`define UART_IO_CMD_WRITE 32'd1
`define UART_IO_CMD_READ  32'd2

// register bank size
`define UART_IO_REG_COUNT 16

// response status codes
`define UART_IO_ST_OK       32'd0
`define UART_IO_ST_BAD_ADDR 32'd1
`define UART_IO_ST_BAD_CMD  32'd2

`endif

/* hw/uart_io_pkg.sv */
// uart io bridge types
`default_nettype none

package uart_io_pkg;

	typedef logic [7:0]  byte_t;    // one uart byte
	typedef logic [31:0] word_t;    // cmd, addr, data or status
	typedef logic [3:0]  reg_idx_t; // register index

	// request as sent by the host, msb first on the wire
	typedef struct packed {
		word_t cmd;
		word_t addr;
		word_t data;
	} host_req_t;

	// response as returned by the handler
	typedef struct packed {
		word_t status;
		word_t addr;
		word_t data;
	} host_rsp_t;

	// host model, request side
	typedef enum logic [1:0] {
		rx_idle,
		rx_send_bytes,
		rx_wait_rsp
	} faux_rx_state_t;

	// host model, response side
	typedef enum logic {
		tx_read_id,
		tx_read_words
	} faux_tx_state_t;

	// handler fsm
	typedef enum logic [2:0] {
		h_hunt_id,
		h_collect,
		h_access,
		h_read_wait,
		h_send
	} handler_state_t;

endpackage

`default_nettype wire

/* hw/reg_bank.sv */
// 32-bit register bank
`timescale 1ns/10ps
`default_nettype none
`include "uart_io_params.svh"

module reg_bank (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  access,     // one cycle strobe
	input  logic                  write,      // else read
	input  uart_io_pkg::reg_idx_t idx,
	input  uart_io_pkg::word_t    addr_word,  // full address for range check
	input  uart_io_pkg::word_t    wr_data,
	output uart_io_pkg::word_t    rd_data,    // registered
	output logic                  addr_error  // registered, with rd_data
);
	import uart_io_pkg::*;

	word_t regs [`UART_IO_REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `UART_IO_REG_COUNT; i++)
				regs[i] <= '0; // bank reads 0 until written
			rd_data    <= '0;
			addr_error <= 1'b0;
		end else if (access) begin
			if (addr_word >= 32'(`UART_IO_REG_COUNT)) begin
				addr_error <= 1'b1; // out of range, bank untouched
				rd_data    <= '0;
			end else begin
				addr_error <= 1'b0;
				if (write)
					regs[idx] <= wr_data;
				else
					rd_data <= regs[idx];
			end
		end
	end

	// handler fsm must be parked while reset is held
	a_no_access_in_rst: assert property (@(posedge clk)
		rst |-> !access);

endmodule

`default_nettype wire

/* hw/faux_uart.sv */
// byte level host model
`timescale 1ns/10ps
`default_nettype none
`include "uart_io_params.svh"

module faux_uart (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,           // kick off one request
	input  uart_io_pkg::host_req_t req,            // sampled with start
	input  logic                  transmit,        // handler has a byte for us
	input  uart_io_pkg::byte_t    tx_byte,         // that byte
	output logic                  received,        // one cycle, rx_byte valid
	output uart_io_pkg::byte_t    rx_byte,         // request byte to handler
	output logic                  is_receiving,    // request playing out
	output logic                  is_transmitting, // byte delay after each accept
	output logic                  busy,            // transaction in flight
	output logic                  rsp_valid,       // one cycle, rsp valid
	output uart_io_pkg::host_rsp_t rsp,            // collected response
	output logic                  rsp_error        // bad response id
);
	import uart_io_pkg::*;

	localparam int pkt_bits       = 8 * `UART_IO_PKT_BYTES;
	localparam int last_pkt_byte  = `UART_IO_PKT_BYTES - 1; // rx side, id included
	localparam int last_word_byte = `UART_IO_PKT_BYTES - 2; // tx side, id excluded

	faux_rx_state_t rx_state;
	faux_tx_state_t tx_state;

	logic [7:0] rx_timer; // countdown to next request byte
	logic [7:0] tx_timer; // countdown to end of is_transmitting
	logic [3:0] rx_cnt;   // request bytes sent
	logic [3:0] tx_cnt;   // response word bytes taken

	logic [pkt_bits-1:0] pkt_sr; // outgoing request, msb first

	logic rsp_done; // 13th response byte accepted this cycle
	logic rsp_bad;  // id byte wrong this cycle

	assign rsp_done = transmit && (tx_state == tx_read_words) &&
		(tx_cnt == 4'(last_word_byte));
	assign rsp_bad = transmit && (tx_state == tx_read_id) && (tx_byte != `UART_IO_CHAR_S);

	// request side, plays out 'L' then cmd, addr, data
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_state     <= rx_idle;
			received     <= 1'b0;
			is_receiving <= 1'b0;
			busy         <= 1'b0;
			rx_timer     <= 8'd0;
			rx_cnt       <= 4'd0;
		end else begin
			received <= 1'b0; // pulse only
			case (rx_state)
				rx_idle: begin
					if (start) begin // start only honoured here
						pkt_sr       <= {`UART_IO_CHAR_L, req};
						rx_timer     <= 8'(`UART_IO_BYTE_DELAY);
						rx_cnt       <= 4'd0;
						is_receiving <= 1'b1;
						busy         <= 1'b1;
						rx_state     <= rx_send_bytes;
					end
				end
				rx_send_bytes: begin
					if (rx_timer == 8'd1) begin // delay elapsed, emit byte
						received <= 1'b1;
						rx_byte  <= pkt_sr[pkt_bits-1 -: 8];
						pkt_sr   <= {pkt_sr[pkt_bits-9:0], 8'h00};
						rx_timer <= 8'(`UART_IO_BYTE_DELAY);
						rx_cnt   <= rx_cnt + 4'd1;
						if (rx_cnt == 4'(last_pkt_byte)) begin
							is_receiving <= 1'b0; // last byte out
							rx_state     <= rx_wait_rsp;
						end
					end else begin
						rx_timer <= rx_timer - 8'd1;
					end
				end
				rx_wait_rsp: begin
					// busy drops together with rsp_valid or rsp_error
					if (rsp_done || rsp_bad) begin
						busy     <= 1'b0;
						rx_state <= rx_idle;
					end
				end
				default: rx_state <= rx_idle;
			endcase
		end
	end

	// response side, checks id then shifts in 12 bytes
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_state        <= tx_read_id;
			is_transmitting <= 1'b0;
			tx_timer        <= 8'd0;
			tx_cnt          <= 4'd0;
			rsp_valid       <= 1'b0;
			rsp_error       <= 1'b0;
		end else begin
			rsp_valid <= rsp_done; // cycle after last byte
			rsp_error <= rsp_bad;

			// back-pressure, high for the byte delay after each accept
			if (transmit) begin
				is_transmitting <= 1'b1;
				tx_timer        <= 8'(`UART_IO_BYTE_DELAY);
			end else if (tx_timer == 8'd1) begin
				is_transmitting <= 1'b0;
				tx_timer        <= 8'd0;
			end else if (tx_timer != 8'd0) begin
				tx_timer <= tx_timer - 8'd1;
			end

			case (tx_state)
				tx_read_id: begin
					if (transmit && tx_byte == `UART_IO_CHAR_S) begin
						tx_cnt   <= 4'd0;
						tx_state <= tx_read_words;
					end
				end
				tx_read_words: begin
					if (transmit) begin
						rsp    <= {rsp[87:0], tx_byte}; // status first
						tx_cnt <= tx_cnt + 4'd1;
						if (tx_cnt == 4'(last_word_byte))
							tx_state <= tx_read_id;
					end
				end
				default: tx_state <= tx_read_id;
			endcase
		end
	end

	// request bytes are spaced by the delay, never back to back
	a_rx_single: assert property (@(posedge clk) disable iff (rst)
		received |=> !received);

endmodule

`default_nettype wire

/* hw/uart_io_handler.sv */
// uart command handler
`timescale 1ns/10ps
`default_nettype none
`include "uart_io_params.svh"

module uart_io_handler (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  received,        // byte strobe from host
	input  uart_io_pkg::byte_t    rx_byte,
	input  logic                  is_transmitting, // host still pacing last byte
	input  uart_io_pkg::word_t    rd_data,         // from bank, cycle after access
	input  logic                  addr_error,      // from bank, cycle after access
	output logic                  transmit,        // byte strobe to host
	output uart_io_pkg::byte_t    tx_byte,
	output logic                  access,          // bank strobe
	output logic                  write,
	output uart_io_pkg::reg_idx_t idx,
	output uart_io_pkg::word_t    wr_data,
	output uart_io_pkg::word_t    addr_word
);
	import uart_io_pkg::*;

	localparam int pkt_bits       = 8 * `UART_IO_PKT_BYTES;
	localparam int last_word_byte = `UART_IO_PKT_BYTES - 2; // after the id
	localparam int last_pkt_byte  = `UART_IO_PKT_BYTES - 1;

	handler_state_t state;

	logic [3:0] byte_cnt; // shared by collect and send

	host_req_t req_q;    // collected request
	host_req_t req_next; // request with the current byte shifted in
	host_rsp_t rsp_word; // response after a bank access
	logic      cmd_valid;

	logic [pkt_bits-1:0] tx_sr; // outgoing packet, msb first

	assign req_next  = {req_q[87:0], rx_byte};
	assign cmd_valid = (req_next.cmd == `UART_IO_CMD_WRITE) ||
		(req_next.cmd == `UART_IO_CMD_READ); // only valid on the last byte

	// bank side comes straight off the request
	assign access    = (state == h_access); // single cycle state
	assign write     = (req_q.cmd == `UART_IO_CMD_WRITE);
	assign idx       = req_q.addr[$bits(reg_idx_t)-1:0];
	assign wr_data   = req_q.data;
	assign addr_word = req_q.addr; // full word, bank does the range check

	assign tx_byte = tx_sr[pkt_bits-1 -: 8];

	// response once the bank has answered
	always_comb begin
		rsp_word.addr = req_q.addr; // address always echoed
		if (addr_error) begin
			rsp_word.status = `UART_IO_ST_BAD_ADDR;
			rsp_word.data   = 32'h0;
		end else begin
			rsp_word.status = `UART_IO_ST_OK;
			rsp_word.data   = write ? req_q.data : rd_data; // write echoes data
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= h_hunt_id;
			byte_cnt <= 4'd0;
			transmit <= 1'b0;
		end else begin
			case (state)
				h_hunt_id: begin
					// junk before the id is dropped
					if (received && rx_byte == `UART_IO_CHAR_L) begin
						byte_cnt <= 4'd0;
						state    <= h_collect;
					end
				end
				h_collect: begin
					if (received) begin
						req_q    <= req_next;
						byte_cnt <= byte_cnt + 4'd1;
						if (byte_cnt == 4'(last_word_byte)) begin
							if (cmd_valid) begin
								state <= h_access; // strobe next cycle
							end else begin
								// unknown command, answer without touching the bank
								tx_sr <= {`UART_IO_CHAR_S, `UART_IO_ST_BAD_CMD,
									req_next.addr, 32'h0};
								byte_cnt <= 4'd0;
								transmit <= 1'b1;
								state    <= h_send;
							end
						end
					end
				end
				h_access: state <= h_read_wait; // bank registers its answer
				h_read_wait: begin
					tx_sr    <= {`UART_IO_CHAR_S, rsp_word};
					byte_cnt <= 4'd0;
					transmit <= 1'b1; // first byte next cycle
					state    <= h_send;
				end
				h_send: begin
					if (transmit) begin // host takes it this cycle
						transmit <= 1'b0;
						tx_sr    <= {tx_sr[pkt_bits-9:0], 8'h00};
						byte_cnt <= byte_cnt + 4'd1;
						if (byte_cnt == 4'(last_pkt_byte))
							state <= h_hunt_id;
					end else if (!is_transmitting) begin
						transmit <= 1'b1; // host delay over
					end
				end
				default: state <= h_hunt_id;
			endcase
		end
	end

	// host must be idle whenever a byte is offered
	a_tx_gap: assert property (@(posedge clk) disable iff (rst)
		!(transmit && is_transmitting));

endmodule

`default_nettype wire

/* hw/uart_io_top.sv */
// uart io bridge top
`timescale 1ns/10ps
`default_nettype none

module uart_io_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  uart_io_pkg::host_req_t req,
	output logic                   busy,
	output logic                   rsp_valid,
	output uart_io_pkg::host_rsp_t rsp,
	output logic                   rsp_error
);
	import uart_io_pkg::*;

	// host to handler
	logic     received;
	byte_t    rx_byte;
	logic     is_transmitting;
	// handler to host
	logic     transmit;
	byte_t    tx_byte;
	// handler to bank
	logic     access;
	logic     write;
	reg_idx_t idx;
	word_t    wr_data;
	word_t    addr_word;
	word_t    rd_data;
	logic     addr_error;

	faux_uart u_faux_uart (
		.clk             (clk),
		.rst             (rst),
		.start           (start),
		.req             (req),
		.transmit        (transmit),
		.tx_byte         (tx_byte),
		.received        (received),
		.rx_byte         (rx_byte),
		.is_receiving    (), // handler works off received alone
		.is_transmitting (is_transmitting),
		.busy            (busy),
		.rsp_valid       (rsp_valid),
		.rsp             (rsp),
		.rsp_error       (rsp_error)
	);

	uart_io_handler u_handler (
		.clk             (clk),
		.rst             (rst),
		.received        (received),
		.rx_byte         (rx_byte),
		.is_transmitting (is_transmitting),
		.rd_data         (rd_data),
		.addr_error      (addr_error),
		.transmit        (transmit),
		.tx_byte         (tx_byte),
		.access          (access),
		.write           (write),
		.idx             (idx),
		.wr_data         (wr_data),
		.addr_word       (addr_word)
	);

	reg_bank u_reg_bank (
		.clk        (clk),
		.rst        (rst),
		.access     (access),
		.write      (write),
		.idx        (idx),
		.addr_word  (addr_word),
		.wr_data    (wr_data),
		.rd_data    (rd_data),
		.addr_error (addr_error)
	);

endmodule

`default_nettype wire

/* bench/uart_io_model.svh */
// register bank reference model
`ifndef UART_IO_MODEL_SVH
`define UART_IO_MODEL_SVH

word_t model_regs [`UART_IO_REG_COUNT]; // mirror of the bank contents

// bank clears on reset
function automatic void model_reset();
	for (int i = 0; i < `UART_IO_REG_COUNT; i++)
		model_regs[i] = '0;
endfunction

// expected response, applies a write to the mirror
function automatic host_rsp_t predict(input host_req_t r);
	host_rsp_t p;
	p.addr = r.addr; // address always echoed
	if (r.cmd != `UART_IO_CMD_WRITE && r.cmd != `UART_IO_CMD_READ) begin
		p.status = `UART_IO_ST_BAD_CMD; // bank never touched
		p.data   = 32'h0;
	end else if (r.addr >= `UART_IO_REG_COUNT) begin
		p.status = `UART_IO_ST_BAD_ADDR;
		p.data   = 32'h0;
	end else if (r.cmd == `UART_IO_CMD_WRITE) begin
		model_regs[r.addr[3:0]] = r.data;
		p.status = `UART_IO_ST_OK;
		p.data   = r.data; // write echoes its data
	end else begin
		p.status = `UART_IO_ST_OK;
		p.data   = model_regs[r.addr[3:0]];
	end
	return p;
endfunction

`endif

/* bench/uart_io_tb.sv */
// uart io bridge testbench
`timescale 1ns/10ps
`default_nettype none
`include "uart_io_params.svh"

module uart_io_tb;
	import uart_io_pkg::*;
	`include "uart_io_model.svh"

	localparam int num_random   = 200;
	localparam int num_directed = 27; // reset reads, bad address, bad command
	localparam int max_wait     = 600; // cycles per transaction, generous
	localparam longint timeout_ns = longint'(num_random + num_directed) * max_wait * 10;

	logic      clk;
	logic      rst;
	logic      start;
	host_req_t req;
	logic      busy;
	logic      rsp_valid;
	host_rsp_t rsp;
	logic      rsp_error;

	integer seed = 37872;
	int     errors;
	int     txns;      // accepted starts
	int     rsp_count; // rsp_valid pulses seen
	int     first_err; // error count at test start

	uart_io_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.req       (req),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_error (rsp_error)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// counts responses, flags a bad id from the handler
	always @(posedge clk) begin
		if (rsp_valid)
			rsp_count++;
		if (!rst)
			assert (!rsp_error) else begin
				$display("response packet did not start with the S id byte");
				errors++;
			end
	end

	// one clock, then the drive point
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		assert (got === exp) else begin
			$display("FAILED %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	function automatic host_req_t make_req(input word_t cmd, input word_t addr, input word_t data);
		host_req_t r;
		r.cmd  = cmd;
		r.addr = addr;
		r.data = data;
		return r;
	endfunction

	// write 45, read 45, junk command 10 percent
	function automatic host_req_t random_req();
		host_req_t r;
		int unsigned sel;
		sel = $unsigned($random(seed)) % 100;
		if (sel < 45) begin
			r.cmd = `UART_IO_CMD_WRITE;
		end else if (sel < 90) begin
			r.cmd = `UART_IO_CMD_READ;
		end else begin
			r.cmd = $random(seed);
			if (r.cmd == `UART_IO_CMD_WRITE || r.cmd == `UART_IO_CMD_READ)
				r.cmd = 32'h0; // keep it invalid
		end
		r.addr = $unsigned($random(seed)) % 20; // 16..19 out of range
		r.data = $random(seed);
		return r;
	endfunction

	// one start, one response; inject stray starts while busy if asked
	task automatic run_txn(input host_req_t r, input bit inject);
		host_rsp_t exp;
		int        waited;
		while (busy)
			step();
		start = 1'b1;
		req   = r;
		exp   = predict(r);
		step();
		start = 1'b0;
		assert (busy) else begin
			$display("busy did not rise the cycle after start");
			errors++;
		end
		waited = 0;
		while (waited < max_wait && !rsp_valid) begin
			if (inject && busy && ($unsigned($random(seed)) % 8 == 0)) begin
				start = 1'b1; // must be ignored
				req   = random_req();
			end
			step();
			start = 1'b0;
			waited++;
		end
		assert (rsp_valid) else begin
			$display("no response within %0d cycles of start", max_wait);
			errors++;
		end
		if (rsp_valid) begin
			check_word("rsp.status", exp.status, rsp.status);
			check_word("rsp.addr", exp.addr, rsp.addr);
			check_word("rsp.data", exp.data, rsp.data);
			assert (!busy) else begin
				$display("busy still high in the rsp_valid cycle");
				errors++;
			end
		end
		txns++;
	endtask

	task automatic end_test(input string name);
		$display("test %s done, %0d errors", name, errors - first_err);
	endtask

	initial begin
		rst       = 1'b1;
		start     = 1'b0;
		req       = '0;
		errors    = 0;
		txns      = 0;
		rsp_count = 0;
		model_reset();
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		step();

		// whole bank reads 0 out of reset
		first_err = errors;
		for (int i = 0; i < `UART_IO_REG_COUNT; i++)
			run_txn(make_req(`UART_IO_CMD_READ, i, 32'h0), 1'b0);
		end_test("reset_reads");

		// out of range writes must not alias
		first_err = errors;
		for (int a = 16; a < 20; a++) begin
			run_txn(make_req(`UART_IO_CMD_WRITE, a, $random(seed)), 1'b0);
			run_txn(make_req(`UART_IO_CMD_READ, a - 16, 32'h0), 1'b0);
		end
		end_test("bad_addr");

		first_err = errors;
		run_txn(make_req(`UART_IO_CMD_WRITE, 32'd5, 32'hcafe_0005), 1'b0);
		run_txn(make_req(32'd3, 32'd5, 32'h1234_5678), 1'b0); // unknown command
		run_txn(make_req(`UART_IO_CMD_READ, 32'd5, 32'h0), 1'b0);
		end_test("bad_cmd");

		first_err = errors;
		for (int n = 0; n < num_random; n++)
			run_txn(random_req(), 1'b1);
		end_test("random");

		repeat (20) step(); // let the monitor catch any stray pulse
		assert (rsp_count == txns) else begin
			$display("FAILED rsp_count: expected %h, got %h", txns, rsp_count);
			errors++;
		end
		$display("summary: 4 tests, %0d transactions, %0d responses, %0d errors",
			txns, rsp_count, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// bound on total run time
	initial begin
		#(timeout_ns);
		$display("watchdog expired before all transactions finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
+incdir+bench
hw/uart_io_pkg.sv
hw/reg_bank.sv
hw/faux_uart.sv
hw/uart_io_handler.sv
hw/uart_io_top.sv
bench/uart_io_tb.sv
